//--- common/core_pkg.sv
package core_pkg;

    // Instruction addresses are word addresses
    localparam int im_addr_bit = 30;

    localparam int data_bit = 32;
    localparam int reg_addr_bit = 5;

    // Data memory geometry
    localparam int dmem_words = 256;
    localparam int dmem_addr_bit = $clog2(dmem_words);

    // Source of the register write data
    typedef enum logic [1:0] {
        wb_alu = 2'd0,  // ALU result
        wb_mem = 2'd1,  // Loaded word
        wb_pc4 = 2'd2,  // Return address
        wb_cp0 = 2'd3   // CP0 read value
    } wb_sel_t;

endpackage

//--- common/stage_pkg.sv
package stage_pkg;

    import core_pkg::*;

    // Payload handed over by the execute stage
    typedef struct packed {
        logic [im_addr_bit-1:0] pc_4;
        logic regfile_w_en;
        logic [reg_addr_bit-1:0] regfile_req_w;
        logic [data_bit-1:0] alu_data_res;  // Also the memory byte address
        logic [data_bit-1:0] store_data;
        logic mem_read;
        logic mem_write;
        wb_sel_t mux_regfile_data_w;
        logic halt;
        logic [data_bit-1:0] cp0_data;
    } ex_mem_t;

    typedef struct packed {
        logic [im_addr_bit-1:0] pc_4;
        logic regfile_w_en;
        logic [reg_addr_bit-1:0] regfile_req_w;
        logic [data_bit-1:0] alu_data_res;
        logic [data_bit-1:0] datamem_data;
        wb_sel_t mux_regfile_data_w;
        logic halt;
        logic [data_bit-1:0] cp0_data;
    } mem_wb_t;

    // Register file write port
    typedef struct packed {
        logic w_en;
        logic [reg_addr_bit-1:0] addr;
        logic [data_bit-1:0] data;
    } reg_write_t;

endpackage

//--- data_mem/data_mem.sv
module data_mem (
    input  logic                          clk,
    input  logic [core_pkg::dmem_addr_bit-1:0] addr,
    input  logic                          w_en,
    input  logic [31:0]                   w_data,
    output logic [31:0]                   r_data
);

    import core_pkg::*;

    logic [data_bit-1:0] mem [dmem_words];

    // Asynchronous read, new data visible the cycle after a write
    assign r_data = mem[addr];

    always_ff @(posedge clk) begin
        if (w_en) begin
            mem[addr] <= w_data;
        end
    end

endmodule

//--- regfile/regfile.sv
module regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  stage_pkg::reg_write_t             reg_wr,
    input  logic [core_pkg::reg_addr_bit-1:0] rd_addr_a,
    input  logic [core_pkg::reg_addr_bit-1:0] rd_addr_b,
    output logic [core_pkg::data_bit-1:0]     rd_data_a,
    output logic [core_pkg::data_bit-1:0]     rd_data_b
);

    import core_pkg::*;

    localparam int num_regs = 2 ** reg_addr_bit;

    logic [data_bit-1:0] regs [num_regs];

    // One read port, with write-through bypass
    function automatic logic [data_bit-1:0] read_port(
        input logic [reg_addr_bit-1:0] addr
    );
        logic [data_bit-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (reg_wr.w_en && reg_wr.addr == addr) begin
            value = reg_wr.data;  // Same-cycle write
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.w_en) begin
            regs[reg_wr.addr] <= reg_wr.data;
        end
    end

    // Writeback filters register 0 before it gets here
    a_no_r0_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_wr.w_en |-> reg_wr.addr != '0
    );

endmodule

//--- source/mem_stage.sv
module mem_stage (
    input  logic               clk,
    input  stage_pkg::ex_mem_t ex_mem_in,
    input  logic               en,
    input  logic               clear,
    output stage_pkg::mem_wb_t mem_wb_out
);

    import core_pkg::*;

    logic [dmem_addr_bit-1:0] word_addr;
    logic                     store_en;
    logic [data_bit-1:0]      load_word;

    // Byte address to word index
    assign word_addr = ex_mem_in.alu_data_res[dmem_addr_bit+1:2];

    // No store from a stalled or flushed slot
    assign store_en = ex_mem_in.mem_write & en & ~clear;

    data_mem u_data_mem (
        .clk    (clk),
        .addr   (word_addr),
        .w_en   (store_en),
        .w_data (ex_mem_in.store_data),
        .r_data (load_word)
    );

    always_comb begin
        mem_wb_out.pc_4               = ex_mem_in.pc_4;
        mem_wb_out.regfile_w_en       = ex_mem_in.regfile_w_en;
        mem_wb_out.regfile_req_w      = ex_mem_in.regfile_req_w;
        mem_wb_out.alu_data_res       = ex_mem_in.alu_data_res;
        mem_wb_out.mux_regfile_data_w = ex_mem_in.mux_regfile_data_w;
        mem_wb_out.halt               = ex_mem_in.halt;
        mem_wb_out.cp0_data           = ex_mem_in.cp0_data;
        mem_wb_out.datamem_data       = ex_mem_in.mem_read ? load_word : '0;
    end

    // Decode never issues a load and a store together
    a_no_load_store : assert property (
        @(posedge clk) !(ex_mem_in.mem_read && ex_mem_in.mem_write)
    );

endmodule

//--- source/mem_wb_reg.sv
module mem_wb_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               clear,
    input  stage_pkg::mem_wb_t d,
    output stage_pkg::mem_wb_t q
);

    // Flush wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;  // Bubble
        end else if (en) begin
            q <= d;
        end
    end

    // A flushed slot must never reach the register file
    a_clear_kills_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |=> !q.regfile_w_en
    );

endmodule

//--- source/writeback_unit.sv
module writeback_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      en,
    input  logic                      clear,
    input  stage_pkg::mem_wb_t        wb,
    output stage_pkg::reg_write_t     reg_wr,
    output logic                      halted,
    output logic [core_pkg::data_bit-1:0] retired
);

    import core_pkg::*;

    logic                valid;      // Slot was freshly accepted
    logic                halt_seen;
    logic [data_bit-1:0] wr_data;

    always_comb begin
        case (wb.mux_regfile_data_w)
            wb_mem:  wr_data = wb.datamem_data;
            wb_pc4:  wr_data = {wb.pc_4, 2'b00};  // Back to byte address
            wb_cp0:  wr_data = wb.cp0_data;
            default: wr_data = wb.alu_data_res;
        endcase
    end

    // Register 0 is dropped here, not in the register file
    assign reg_wr.w_en = wb.regfile_w_en && (wb.regfile_req_w != '0);
    assign reg_wr.addr = wb.regfile_req_w;
    assign reg_wr.data = wr_data;

    assign halted = halt_seen | wb.halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            halt_seen <= 1'b0;
            retired   <= '0;
        end else begin
            valid <= en & ~clear;
            if (wb.halt) begin
                halt_seen <= 1'b1;
            end
            // A held slot counts only once
            if (valid && (wb.regfile_w_en || wb.halt)) begin
                retired <= retired + 1'b1;
            end
        end
    end

endmodule

//--- source/backend_top.sv
module backend_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  logic                              clear,
    input  stage_pkg::ex_mem_t                ex_mem_in,
    input  logic [core_pkg::reg_addr_bit-1:0] rd_addr_a,
    input  logic [core_pkg::reg_addr_bit-1:0] rd_addr_b,
    output logic [core_pkg::data_bit-1:0]     rd_data_a,
    output logic [core_pkg::data_bit-1:0]     rd_data_b,
    output logic                              halted,
    output logic [core_pkg::data_bit-1:0]     retired
);

    import stage_pkg::*;

    mem_wb_t    mem_wb_d;
    mem_wb_t    mem_wb_q;
    reg_write_t reg_wr;

    mem_stage u_mem_stage (
        .clk        (clk),
        .ex_mem_in  (ex_mem_in),
        .en         (en),
        .clear      (clear),
        .mem_wb_out (mem_wb_d)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .clear (clear),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    writeback_unit u_writeback (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .clear   (clear),
        .wb      (mem_wb_q),
        .reg_wr  (reg_wr),
        .halted  (halted),
        .retired (retired)
    );

    // Decode side reads here
    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

//--- dv/backend_tb.sv
module backend_tb;

    import core_pkg::*;
    import stage_pkg::*;

    localparam int num_entries = 21;
    localparam int reset_cycles = 5;
    localparam int timeout_cycles = num_entries + reset_cycles + 20;

    logic clk;
    logic rst_n;
    logic en;
    logic clear;
    ex_mem_t ex_mem_in;
    logic [reg_addr_bit-1:0] rd_addr_a;
    logic [reg_addr_bit-1:0] rd_addr_b;
    logic [data_bit-1:0] rd_data_a;
    logic [data_bit-1:0] rd_data_b;
    logic halted;
    logic [data_bit-1:0] retired;

    // Stimulus table
    string name_tbl [num_entries];
    ex_mem_t pl_tbl [num_entries];
    logic en_tbl [num_entries];
    logic clear_tbl [num_entries];
    logic [reg_addr_bit-1:0] chk_tbl [num_entries];
    logic [data_bit-1:0] exp_tbl [num_entries];
    bit compute_tbl [num_entries];  // Expected value comes from the model
    int entry_count = 0;

    // Reference model
    logic [data_bit-1:0] model_regs [32];
    logic [data_bit-1:0] model_mem [dmem_words];
    logic [data_bit-1:0] model_retired;
    logic model_halted;
    logic last_retire;  // Entry not yet visible on retired

    logic [31:0] lfsr_state;
    int cycle_count = 0;
    int checks = 0;
    int errors = 0;

    backend_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .clear     (clear),
        .ex_mem_in (ex_mem_in),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .halted    (halted),
        .retired   (retired)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the stimulus never finished", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic next_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic ex_mem_t alu_payload(input logic [4:0] rd, input logic [31:0] value);
        ex_mem_t p;
        p = '0;
        p.regfile_w_en = 1'b1;
        p.regfile_req_w = rd;
        p.alu_data_res = value;
        p.mux_regfile_data_w = wb_alu;
        return p;
    endfunction

    function automatic ex_mem_t store_payload(input logic [31:0] addr, input logic [31:0] data);
        ex_mem_t p;
        p = '0;
        p.alu_data_res = addr;
        p.store_data = data;
        p.mem_write = 1'b1;
        return p;
    endfunction

    function automatic ex_mem_t load_payload(input logic [4:0] rd, input logic [31:0] addr);
        ex_mem_t p;
        p = alu_payload(rd, addr);
        p.mem_read = 1'b1;
        p.mux_regfile_data_w = wb_mem;
        return p;
    endfunction

    function automatic ex_mem_t link_payload(input logic [4:0] rd, input logic [29:0] pc);
        ex_mem_t p;
        p = alu_payload(rd, 32'h0000_0bad);
        p.pc_4 = pc;
        p.mux_regfile_data_w = wb_pc4;
        return p;
    endfunction

    function automatic ex_mem_t cp0_payload(input logic [4:0] rd, input logic [31:0] value);
        ex_mem_t p;
        p = alu_payload(rd, ~value);
        p.cp0_data = value;
        p.mux_regfile_data_w = wb_cp0;
        return p;
    endfunction

    function automatic ex_mem_t halt_payload();
        ex_mem_t p;
        p = '0;
        p.halt = 1'b1;
        return p;
    endfunction

    task automatic add_entry(input string name, input ex_mem_t pl, input logic en_v,
                             input logic clear_v, input logic [4:0] chk,
                             input logic [31:0] exp_v, input bit compute);
        if (entry_count < num_entries) begin
            name_tbl[entry_count] = name;
            pl_tbl[entry_count] = pl;
            en_tbl[entry_count] = en_v;
            clear_tbl[entry_count] = clear_v;
            chk_tbl[entry_count] = chk;
            exp_tbl[entry_count] = exp_v;
            compute_tbl[entry_count] = compute;
        end
        entry_count++;
    endtask

    // Effect of one entry once it passes the memory stage
    task automatic apply_model(input ex_mem_t p, input logic acc_en, input logic acc_clear);
        logic [dmem_addr_bit-1:0] word;
        logic [31:0] wdata;
        last_retire = 1'b0;
        if (acc_en && !acc_clear) begin
            word = p.alu_data_res[9:2];
            if (p.mux_regfile_data_w == wb_mem) begin
                wdata = p.mem_read ? model_mem[word] : 32'd0;
            end else if (p.mux_regfile_data_w == wb_pc4) begin
                wdata = {p.pc_4, 2'b00};
            end else if (p.mux_regfile_data_w == wb_cp0) begin
                wdata = p.cp0_data;
            end else begin
                wdata = p.alu_data_res;
            end
            if (p.mem_write) begin
                model_mem[word] = p.store_data;
            end
            if (p.regfile_w_en && p.regfile_req_w != 5'd0) begin
                model_regs[p.regfile_req_w] = wdata;
            end
            if (p.regfile_w_en || p.halt) begin
                model_retired = model_retired + 32'd1;
                last_retire = 1'b1;
            end
            if (p.halt) begin
                model_halted = 1'b1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Runs in the cycle after entry k was applied
    task automatic check_entry(input int k);
        logic [31:0] expected;
        logic [31:0] expected_retired;
        expected = compute_tbl[k] ? model_regs[chk_tbl[k]] : exp_tbl[k];
        check_value(name_tbl[k], expected, rd_data_a);  // Bypassed read
        if (k > 0) begin
            check_value({name_tbl[k-1], "_commit"}, model_regs[chk_tbl[k-1]], rd_data_b);
        end
        expected_retired = last_retire ? model_retired - 32'd1 : model_retired;
        check_value({name_tbl[k], "_retired"}, expected_retired, retired);
        check_value({name_tbl[k], "_halted"}, {31'd0, model_halted}, {31'd0, halted});
    endtask

    initial begin
        logic [31:0] rnd [13];
        clk = 1'b0;
        rst_n = 1'b0;
        en = 1'b0;
        clear = 1'b0;
        ex_mem_in = '0;
        rd_addr_a = '0;
        rd_addr_b = '0;
        lfsr_state = 32'h827d;
        for (int j = 0; j < 32; j++) model_regs[j] = '0;
        for (int j = 0; j < dmem_words; j++) model_mem[j] = '0;
        model_retired = '0;
        model_halted = 1'b0;
        last_retire = 1'b0;
        for (int j = 0; j < 13; j++) next_bits(32, rnd[j]);

        add_entry("alu_r5", alu_payload(5'd5, rnd[0]), 1'b1, 1'b0, 5'd5, rnd[0], 1'b0);
        add_entry("alu_r6", alu_payload(5'd6, rnd[1]), 1'b1, 1'b0, 5'd6, rnd[1], 1'b0);
        add_entry("alu_r0", alu_payload(5'd0, rnd[2]), 1'b1, 1'b0, 5'd0, 32'd0, 1'b0);
        add_entry("store_a", store_payload(32'h0000_0040, rnd[3]), 1'b1, 1'b0, 5'd6, 32'd0, 1'b1);
        add_entry("load_a", load_payload(5'd7, 32'h0000_0040), 1'b1, 1'b0, 5'd7, rnd[3], 1'b0);
        add_entry("store_b", store_payload(32'h0000_0080, rnd[4]), 1'b1, 1'b0, 5'd7, 32'd0, 1'b1);
        add_entry("load_never", load_payload(5'd8, 32'h0000_01c4), 1'b1, 1'b0, 5'd8, 32'd0, 1'b1);
        add_entry("load_b", load_payload(5'd9, 32'h0000_0080), 1'b1, 1'b0, 5'd9, rnd[4], 1'b0);
        add_entry("link_r10", link_payload(5'd10, 30'h0040_0011), 1'b1, 1'b0, 5'd10,
                  32'h0100_0044, 1'b0);
        add_entry("cp0_r11", cp0_payload(5'd11, rnd[5]), 1'b1, 1'b0, 5'd11, rnd[5], 1'b0);
        add_entry("alu_r12", alu_payload(5'd12, rnd[6]), 1'b1, 1'b0, 5'd12, rnd[6], 1'b0);
        add_entry("stall_alu", alu_payload(5'd12, rnd[7]), 1'b0, 1'b0, 5'd12, rnd[6], 1'b0);
        add_entry("stall_store", store_payload(32'h0000_0040, rnd[8]), 1'b0, 1'b0, 5'd12,
                  rnd[6], 1'b0);
        add_entry("load_after_stall", load_payload(5'd13, 32'h0000_0040), 1'b1, 1'b0, 5'd13,
                  rnd[3], 1'b0);
        add_entry("flush_alu", alu_payload(5'd5, rnd[9]), 1'b1, 1'b1, 5'd5, rnd[0], 1'b0);
        add_entry("flush_store", store_payload(32'h0000_0080, rnd[10]), 1'b1, 1'b1, 5'd5,
                  32'd0, 1'b1);
        add_entry("load_after_flush", load_payload(5'd14, 32'h0000_0080), 1'b1, 1'b0, 5'd14,
                  rnd[4], 1'b0);
        add_entry("halt", halt_payload(), 1'b1, 1'b0, 5'd14, 32'd0, 1'b1);
        add_entry("alu_after_halt", alu_payload(5'd15, rnd[11]), 1'b1, 1'b0, 5'd15,
                  rnd[11], 1'b0);
        add_entry("stall_after_halt", alu_payload(5'd16, rnd[12]), 1'b0, 1'b0, 5'd15,
                  rnd[11], 1'b0);
        add_entry("idle", '0, 1'b1, 1'b0, 5'd16, 32'd0, 1'b1);
        if (entry_count != num_entries) begin
            errors++;
            $display("Stimulus table has %0d entries but %0d were planned",
                     entry_count, num_entries);
        end

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_retired", 32'd0, retired);
        check_value("reset_halted", 32'd0, {31'd0, halted});

        // One entry per cycle, checks trail by one cycle
        for (int i = 0; i <= num_entries; i++) begin
            @(posedge clk);
            if (i < num_entries) begin
                ex_mem_in <= pl_tbl[i];
                en <= en_tbl[i];
                clear <= clear_tbl[i];
            end else begin
                ex_mem_in <= '0;
                en <= 1'b1;
                clear <= 1'b0;
            end
            if (i > 0) rd_addr_a <= chk_tbl[i-1];
            if (i > 1) rd_addr_b <= chk_tbl[i-2];
            @(negedge clk);
            if (i > 0) check_entry(i - 1);
            if (i < num_entries) apply_model(pl_tbl[i], en_tbl[i], clear_tbl[i]);
        end

        @(posedge clk);
        @(negedge clk);
        check_value("final_retired", model_retired, retired);
        check_value("final_halted", {31'd0, model_halted}, {31'd0, halted});

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
common/core_pkg.sv
common/stage_pkg.sv
data_mem/data_mem.sv
regfile/regfile.sv
source/mem_stage.sv
source/mem_wb_reg.sv
source/writeback_unit.sv
source/backend_top.sv
dv/backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --x-initial 0 \
    -f all.f --top-module backend_tb -o backend_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/backend_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$log"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
